/* list.f */
hw/audio_pkg.sv
hw/voice_ctrl_if.sv
hw/voice_registers.sv
hw/voice_oscillator.sv
hw/voice_mixer.sv
hw/i2s_transmitter.sv
hw/audio_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_audio_subsystem.sv

/* testbench/tb_audio_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_audio_subsystem;

  import audio_pkg::*;

  localparam int VOICES = DEFAULT_VOICE_COUNT;
  localparam int TEST_COUNT = 7;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam int FRAME_CYCLES = 384;
  localparam int WRITE_NONE = 0;
  localparam int WRITE_ALL = 1;
  localparam int WRITE_STEP = 2;  // Step of voice 0 only

  logic      clock_16_934_400;
  logic      reset_l;
  logic      reg_write;
  logic [1:0] reg_address;
  reg_data_t reg_data;
  logic      i2s_bit_clock;
  logic      i2s_left_right_clock;
  logic      i2s_data;

  string     test_name [TEST_COUNT];
  int        write_mode [TEST_COUNT];
  int        frame_count [TEST_COUNT];
  phase_t    tab_step [TEST_COUNT][VOICES];
  waveform_t tab_wave [TEST_COUNT][VOICES];
  level_t    tab_level [TEST_COUNT][VOICES];
  logic      tab_enable [TEST_COUNT][VOICES];

  int   errors;
  int   passed_tests;
  int   failed_tests;
  logic timed_out;

  tb_clock_gen u_clock_gen (
    .clock_16_934_400(clock_16_934_400),
    .reset_l         (reset_l)
  );

  audio_subsystem #(
    .VOICE_COUNT(VOICES)
  ) dut0 (
    .clock_16_934_400    (clock_16_934_400),
    .reset_l             (reset_l),
    .reg_write           (reg_write),
    .reg_address         (reg_address),
    .reg_data            (reg_data),
    .i2s_bit_clock       (i2s_bit_clock),
    .i2s_left_right_clock(i2s_left_right_clock),
    .i2s_data            (i2s_data)
  );

  task automatic define_test(input int t, input string name, input int mode, input int frames);
    test_name[t] = name;
    write_mode[t] = mode;
    frame_count[t] = frames;
  endtask

  task automatic define_voice(input int t, input int v, input phase_t step, input waveform_t wave,
                              input level_t level, input logic enable);
    tab_step[t][v] = step;
    tab_wave[t][v] = wave;
    tab_level[t][v] = level;
    tab_enable[t][v] = enable;
  endtask

  task automatic build_table();
    phase_t saw_step;
    level_t saw_level;
    saw_step = 16'($urandom_range(16'hffff, 1));
    saw_level = 8'($urandom_range(255, 1));
    define_test(0, "reset_idle", WRITE_NONE, 4);
    define_voice(0, 0, 16'h0000, wave_square, 8'd0, 1'b0);
    define_voice(0, 1, 16'h0000, wave_square, 8'd0, 1'b0);
    define_test(1, "square_level_128", WRITE_ALL, 10);
    define_voice(1, 0, 16'h2000, wave_square, 8'd128, 1'b1);  // Sign flips every 4 frames
    define_voice(1, 1, 16'h0000, wave_square, 8'd0, 1'b0);
    define_test(2, "saw_random", WRITE_ALL, 12);
    define_voice(2, 0, saw_step, wave_saw, saw_level, 1'b1);
    define_voice(2, 1, 16'h0400, wave_saw, 8'd255, 1'b0);
    // Level, waveform and enable of voice 0 carry over from the saw test
    define_test(3, "step_rewrite", WRITE_STEP, 8);
    define_voice(3, 0, 16'h0731, wave_saw, saw_level, 1'b1);
    define_voice(3, 1, 16'h0400, wave_saw, 8'd255, 1'b0);
    define_test(4, "square_saturate", WRITE_ALL, 20);
    define_voice(4, 0, 16'h1000, wave_square, 8'd255, 1'b1);
    define_voice(4, 1, 16'h1000, wave_square, 8'd255, 1'b1);
    define_test(5, "second_disabled", WRITE_ALL, 10);
    define_voice(5, 0, 16'h1000, wave_square, 8'd255, 1'b1);
    define_voice(5, 1, 16'h1000, wave_square, 8'd255, 1'b0);
    define_test(6, "two_voice_mix", WRITE_ALL, 8);
    define_voice(6, 0, 16'h0d00, wave_saw, 8'd200, 1'b1);
    define_voice(6, 1, 16'h3000, wave_square, 8'd64, 1'b1);
  endtask

  // Frame k of a test carries the mix at phase k times step
  function automatic int expected_sample(input int t, input int k);
    int sum;
    int wave;
    int v;
    phase_t phase;
    sum = 0;
    for (v = 0; v < VOICES; v++) begin
      phase = phase_t'(k * int'(tab_step[t][v]));
      if (tab_wave[t][v] == wave_saw) begin
        wave = int'($signed(phase));
      end else begin
        wave = phase[15] ? -32768 : 32767;
      end
      if (tab_enable[t][v]) begin
        sum += (wave * int'(tab_level[t][v])) >>> 8;
      end
    end
    if (sum > 32767) sum = 32767;
    if (sum < -32768) sum = -32768;
    return sum;
  endfunction

  function automatic reg_data_t control_word(input int t, input int v);
    return {6'd0, tab_enable[t][v], logic'(tab_wave[t][v]), tab_level[t][v]};
  endfunction

  task automatic report_mismatch(input string name, input string what, input int expected,
                                 input int actual);
    errors++;
    $display("MISMATCH %s %s: expected %0d, actual %0d", name, what, expected, actual);
  endtask

  task automatic flag_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("ERROR: no %s seen within %0d clock cycles", what, TIMEOUT_CYCLES);
  endtask

  task automatic write_register(input logic [1:0] address, input reg_data_t data);
    reg_write = 1'b1;
    reg_address = address;
    reg_data = data;
    @(negedge clock_16_934_400);
    reg_write = 1'b0;
  endtask

  // Outputs change on rising clock edges and are sampled on falling ones
  task automatic wait_lr_edge(input logic level_after, output int cycles);
    logic last;
    cycles = 0;
    if (timed_out) return;
    last = i2s_left_right_clock;
    while (cycles < TIMEOUT_CYCLES) begin
      @(negedge clock_16_934_400);
      cycles++;
      if (i2s_left_right_clock == level_after && last != level_after) return;
      last = i2s_left_right_clock;
    end
    flag_timeout("word clock edge");
  endtask

  task automatic wait_bit_rise();
    logic last;
    int   cycles;
    cycles = 0;
    if (timed_out) return;
    last = i2s_bit_clock;
    while (cycles < TIMEOUT_CYCLES) begin
      @(negedge clock_16_934_400);
      cycles++;
      if (i2s_bit_clock && !last) return;
      last = i2s_bit_clock;
    end
    flag_timeout("rising bit clock");
  endtask

  task automatic capture_word(output sample_t word);
    int b;
    word = '0;
    for (b = 0; b < AUDIO_BIT_WIDTH; b++) begin
      wait_bit_rise();
      word = {word[AUDIO_BIT_WIDTH-2:0], i2s_data};  // MSB first
    end
  endtask

  task automatic run_test(input int t);
    int      errors_before;
    int      cycles;
    int      k;
    int      v;
    int      expected;
    sample_t left;
    sample_t right;
    errors_before = errors;
    if (t == 0) begin
      cycles = 0;
      do begin
        @(posedge clock_16_934_400);
        cycles++;
      end while (reset_l !== 1'b1 && cycles < TIMEOUT_CYCLES);
      if (reset_l !== 1'b1) flag_timeout("reset release");
      @(negedge clock_16_934_400);
      if (i2s_bit_clock !== 1'b1) begin
        report_mismatch(test_name[t], "reset bit clock", 1, i2s_bit_clock);
      end
      if (i2s_left_right_clock !== 1'b0) begin
        report_mismatch(test_name[t], "reset word clock", 0, i2s_left_right_clock);
      end
      if (i2s_data !== 1'b0) begin
        report_mismatch(test_name[t], "reset data", 0, i2s_data);
      end
      wait_lr_edge(1'b0, cycles);
      wait_lr_edge(1'b0, cycles);
      if (!timed_out && cycles != FRAME_CYCLES) begin
        report_mismatch(test_name[t], "word clock period", FRAME_CYCLES, cycles);
      end
    end
    wait_lr_edge(1'b1, cycles);  // Writes go in the middle of a frame
    for (v = 0; v < VOICES && !timed_out; v++) begin
      if (write_mode[t] == WRITE_ALL || (write_mode[t] == WRITE_STEP && v == 0)) begin
        write_register({1'(v), 1'b0}, tab_step[t][v]);
      end
      if (write_mode[t] == WRITE_ALL) begin
        write_register({1'(v), 1'b1}, control_word(t, v));
      end
    end
    wait_lr_edge(1'b0, cycles);
    wait_bit_rise();  // This slot still holds the previous LSB
    for (k = 0; k < frame_count[t]; k++) begin
      capture_word(left);
      capture_word(right);
      if (timed_out) break;
      expected = expected_sample(t, k);
      if (left != expected) begin
        report_mismatch(test_name[t], $sformatf("frame %0d left", k), expected, left);
      end
      if (right != expected) begin
        report_mismatch(test_name[t], $sformatf("frame %0d right", k), expected, right);
      end
      if (right != left) begin
        report_mismatch(test_name[t], $sformatf("frame %0d right vs left", k), left, right);
      end
    end
    if (errors == errors_before) begin
      passed_tests++;
      $display("PASS %s: %0d frames checked", test_name[t], frame_count[t]);
    end else begin
      failed_tests++;
      $display("FAIL %s: %0d errors", test_name[t], errors - errors_before);
    end
  endtask

  initial begin
    reg_write = 1'b0;
    reg_address = 2'b00;
    reg_data = '0;
    errors = 0;
    passed_tests = 0;
    failed_tests = 0;
    timed_out = 1'b0;
    void'($urandom(94285));
    build_table();
    for (int t = 0; t < TEST_COUNT; t++) begin
      if (!timed_out) run_test(t);
    end
    $display("Tests passed %0d, failed %0d, errors %0d", passed_tests, failed_tests, errors);
    if (errors == 0 && !timed_out && passed_tests == TEST_COUNT) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_audio_subsystem

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD = 4,  // 8 ns period
  parameter int RESET_CYCLES = 3
) (
  output logic clock_16_934_400,
  output logic reset_l
);

  initial begin
    clock_16_934_400 = 1'b0;
    forever #(HALF_PERIOD) clock_16_934_400 = ~clock_16_934_400;
  end

  // Reset is released on a falling edge
  initial begin
    reset_l = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock_16_934_400);
    reset_l = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

/* hw/audio_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module audio_subsystem #(
  parameter int VOICE_COUNT = audio_pkg::DEFAULT_VOICE_COUNT
) (
  input  wire logic                 clock_16_934_400,
  input  wire logic                 reset_l,
  input  wire logic                 reg_write,
  input  wire logic [1:0]           reg_address,
  input  wire audio_pkg::reg_data_t reg_data,
  output logic                      i2s_bit_clock,
  output logic                      i2s_left_right_clock,
  output logic                      i2s_data
);

  import audio_pkg::*;

  voice_ctrl_if voice_ctrl [VOICE_COUNT] ();

  sample_t voice_samples [VOICE_COUNT];
  sample_t audio_sample;
  logic    frame_strobe;  // Once per frame at the falling word clock

  voice_registers #(
    .VOICE_COUNT(VOICE_COUNT)
  ) u_registers (
    .clock_16_934_400(clock_16_934_400),
    .reset_l         (reset_l),
    .reg_write       (reg_write),
    .reg_address     (reg_address),
    .reg_data        (reg_data),
    .voices          (voice_ctrl)
  );

  for (genvar v = 0; v < VOICE_COUNT; v++) begin : g_voice
    voice_oscillator u_oscillator (
      .clock_16_934_400(clock_16_934_400),
      .reset_l         (reset_l),
      .ctrl            (voice_ctrl[v]),
      .frame_strobe    (frame_strobe),
      .voice_sample    (voice_samples[v])
    );
  end

  voice_mixer #(
    .VOICE_COUNT(VOICE_COUNT)
  ) u_mixer (
    .clock_16_934_400(clock_16_934_400),
    .reset_l         (reset_l),
    .voice_samples   (voice_samples),
    .audio_sample    (audio_sample)
  );

  i2s_transmitter u_transmitter (
    .clock_16_934_400    (clock_16_934_400),
    .reset_l             (reset_l),
    .audio_sample        (audio_sample),
    .frame_strobe        (frame_strobe),
    .i2s_bit_clock       (i2s_bit_clock),
    .i2s_left_right_clock(i2s_left_right_clock),
    .i2s_data            (i2s_data)
  );

endmodule : audio_subsystem

`default_nettype wire

/* hw/i2s_transmitter.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_transmitter (
  input  wire logic          clock_16_934_400,
  input  wire logic          reset_l,
  input  wire audio_pkg::sample_t audio_sample,
  output logic               frame_strobe,
  output logic               i2s_bit_clock,
  output logic               i2s_left_right_clock,
  output logic               i2s_data
);

  import audio_pkg::*;

  localparam int EDGES = 2;
  localparam int CHANNEL_NUMBER = 2;  // Left and right word per frame

  localparam int BIT_TICKS =
      AUDIO_CLOCK / (AUDIO_SAMPLE_RATE * AUDIO_BIT_WIDTH * CHANNEL_NUMBER * EDGES);
  localparam int LR_TICKS = AUDIO_CLOCK / (AUDIO_SAMPLE_RATE * EDGES);

  localparam int BIT_COUNT_WIDTH = $clog2(BIT_TICKS);
  localparam int LR_COUNT_WIDTH = $clog2(LR_TICKS);

  logic [BIT_COUNT_WIDTH-1:0] bit_count;
  logic [LR_COUNT_WIDTH-1:0]  lr_count;
  logic                       bit_tick;
  logic                       lr_tick;
  logic                       bit_fall;
  sample_t                    sample_q;  // Held for the right word
  logic [AUDIO_BIT_WIDTH-1:0] shift_q;

  assign bit_tick = bit_count == BIT_COUNT_WIDTH'(BIT_TICKS - 1);
  assign lr_tick = lr_count == LR_COUNT_WIDTH'(LR_TICKS - 1);
  assign bit_fall = bit_tick && i2s_bit_clock;

  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      i2s_bit_clock <= 1'b1;
      bit_count     <= '0;
    end else if (bit_tick) begin
      i2s_bit_clock <= ~i2s_bit_clock;
      bit_count     <= '0;
    end else begin
      bit_count <= bit_count + 1'b1;
    end
  end

  // The word counter starts one half bit period short of its end,
  // so the word clock always moves together with a falling bit clock
  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      i2s_left_right_clock <= 1'b0;
      lr_count             <= LR_COUNT_WIDTH'(LR_TICKS - BIT_TICKS);
      frame_strobe         <= 1'b0;
    end else begin
      frame_strobe <= lr_tick && i2s_left_right_clock;  // New frame starts with left
      if (lr_tick) begin
        i2s_left_right_clock <= ~i2s_left_right_clock;
        lr_count             <= '0;
      end else begin
        lr_count <= lr_count + 1'b1;
      end
    end
  end

  // The slot right after a word clock edge still carries the previous LSB
  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      i2s_data <= 1'b0;
      shift_q  <= '0;
      sample_q <= '0;
    end else begin
      if (lr_tick && i2s_left_right_clock) sample_q <= audio_sample;

      if (bit_fall) begin
        i2s_data <= shift_q[AUDIO_BIT_WIDTH-1];
        if (lr_tick) begin
          shift_q <= i2s_left_right_clock ? audio_sample : sample_q;
        end else begin
          shift_q <= {shift_q[AUDIO_BIT_WIDTH-2:0], 1'b0};
        end
      end
    end
  end

endmodule : i2s_transmitter

`default_nettype wire

/* hw/voice_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_mixer #(
  parameter int VOICE_COUNT = audio_pkg::DEFAULT_VOICE_COUNT
) (
  input  wire logic          clock_16_934_400,
  input  wire logic          reset_l,
  input  wire audio_pkg::sample_t voice_samples [VOICE_COUNT],
  output audio_pkg::sample_t audio_sample
);

  import audio_pkg::*;

  // One extra bit per doubling of voices plus headroom
  localparam int SUM_WIDTH = AUDIO_BIT_WIDTH + $clog2(VOICE_COUNT) + 1;

  localparam logic signed [SUM_WIDTH-1:0] SUM_MAX = SUM_WIDTH'(SAMPLE_MAX);
  localparam logic signed [SUM_WIDTH-1:0] SUM_MIN = SUM_WIDTH'(SAMPLE_MIN);

  logic signed [SUM_WIDTH-1:0] sum;

  always_comb begin
    sum = '0;
    for (int i = 0; i < VOICE_COUNT; i++) begin
      sum = sum + SUM_WIDTH'(voice_samples[i]);  // Sign extended
    end
  end

  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      audio_sample <= '0;
    end else if (sum > SUM_MAX) begin
      audio_sample <= SAMPLE_MAX;
    end else if (sum < SUM_MIN) begin
      audio_sample <= SAMPLE_MIN;
    end else begin
      audio_sample <= sum[AUDIO_BIT_WIDTH-1:0];
    end
  end

endmodule : voice_mixer

`default_nettype wire

/* hw/voice_oscillator.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_oscillator (
  input  wire logic         clock_16_934_400,
  input  wire logic         reset_l,
  voice_ctrl_if.oscillator  ctrl,
  input  wire logic         frame_strobe,
  output audio_pkg::sample_t voice_sample
);

  import audio_pkg::*;

  localparam int PHASE_MSB = $bits(phase_t) - 1;
  localparam int LEVEL_SHIFT = $bits(level_t);

  phase_t  phase_q;
  sample_t wave;

  // Wave times level, wide enough for the full product
  logic signed [AUDIO_BIT_WIDTH+LEVEL_SHIFT:0] scaled;

  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      phase_q <= '0;
    end else if (ctrl.clear) begin
      phase_q <= '0;  // A fresh write wins over the frame step
    end else if (frame_strobe) begin
      phase_q <= phase_q + ctrl.step;
    end
  end

  always_comb begin
    if (ctrl.waveform == wave_saw) begin
      wave = $signed(phase_q);
    end else begin
      wave = phase_q[PHASE_MSB] ? SAMPLE_MIN : SAMPLE_MAX;
    end

    // Level is unsigned so it gets a zero sign bit
    scaled = wave * $signed({1'b0, ctrl.level});
  end

  // Taking the upper bits is the arithmetic shift right by 8
  always_ff @(posedge clock_16_934_400, negedge reset_l) begin
    if (!reset_l) begin
      voice_sample <= '0;
    end else if (ctrl.enable) begin
      voice_sample <= scaled[AUDIO_BIT_WIDTH+LEVEL_SHIFT-1:LEVEL_SHIFT];
    end else begin
      voice_sample <= '0;
    end
  end

endmodule : voice_oscillator

`default_nettype wire

/* hw/voice_registers.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_registers #(
  parameter int VOICE_COUNT = audio_pkg::DEFAULT_VOICE_COUNT
) (
  input  wire logic                clock_16_934_400,
  input  wire logic                reset_l,
  input  wire logic                reg_write,
  input  wire logic [1:0]          reg_address,
  input  wire audio_pkg::reg_data_t reg_data,
  voice_ctrl_if.registers          voices [VOICE_COUNT]
);

  import audio_pkg::*;

  // Control word layout
  localparam int LEVEL_MSB = $bits(level_t) - 1;
  localparam int WAVE_BIT = 8;
  localparam int ENABLE_BIT = 9;

  for (genvar v = 0; v < VOICE_COUNT; v++) begin : g_voice
    logic voice_hit;

    // Address bit 1 picks the voice, bit 0 the field
    assign voice_hit = reg_write && (reg_address[1] == 1'(v));

    always_ff @(posedge clock_16_934_400, negedge reset_l) begin
      if (!reset_l) begin
        voices[v].step     <= '0;
        voices[v].level    <= '0;
        voices[v].waveform <= wave_square;
        voices[v].enable   <= 1'b0;
        voices[v].clear    <= 1'b0;
      end else begin
        voices[v].clear <= voice_hit;  // Any write restarts the note at phase zero

        if (voice_hit && !reg_address[0]) begin
          voices[v].step <= reg_data;
        end

        if (voice_hit && reg_address[0]) begin
          voices[v].level    <= reg_data[LEVEL_MSB:0];
          voices[v].waveform <= waveform_t'(reg_data[WAVE_BIT]);
          voices[v].enable   <= reg_data[ENABLE_BIT];
        end
      end
    end
  end

endmodule : voice_registers

`default_nettype wire

/* hw/voice_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface voice_ctrl_if;
  import audio_pkg::*;

  phase_t    step;
  waveform_t waveform;
  level_t    level;
  logic      enable;
  logic      clear;  // One cycle after any write to this voice

  modport registers(output step, output waveform, output level, output enable, output clear);

  modport oscillator(input step, input waveform, input level, input enable, input clear);

endinterface : voice_ctrl_if

`default_nettype wire

/* hw/audio_pkg.sv */
`default_nettype none

package audio_pkg;

  // The system clock is 384 times the sample rate
  localparam int AUDIO_CLOCK = 16934400;
  localparam int AUDIO_SAMPLE_RATE = 44100;
  localparam int AUDIO_BIT_WIDTH = 16;

  localparam int DEFAULT_VOICE_COUNT = 2;

  typedef logic signed [AUDIO_BIT_WIDTH-1:0] sample_t;
  typedef logic [15:0] phase_t;  // Accumulator value and per-frame step
  typedef logic [7:0] level_t;  // 255 is just below full scale
  typedef logic [15:0] reg_data_t;

  // Full-scale limits of one sample
  localparam sample_t SAMPLE_MAX = sample_t'(16'sh7fff);
  localparam sample_t SAMPLE_MIN = sample_t'(16'sh8000);

  typedef enum logic {
    wave_square = 1'b0,
    wave_saw    = 1'b1
  } waveform_t;

endpackage : audio_pkg

`default_nettype wire
